// ==== src/pt_walk_pkg.sv ====
// Page table walker shared definitions
// Widths, page table entry format, walker state and port structs

package pt_walk_pkg;

    // ============================================================
    // Table geometry
    // ============================================================

    // One page table entry
    localparam int PTE_BITS = 64;
    // Entries per memory line
    localparam int LINE_WORDS = 8;
    localparam int LINE_BITS = PTE_BITS * LINE_WORDS;
    localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);

    // Each level consumes 9 bits of the virtual page
    localparam int PAGE_IDX_BITS = 9;
    localparam int MAX_DEPTH = 4;
    localparam int DEPTH_BITS = $clog2(MAX_DEPTH);

    // Page indices are 4KB granular
    localparam int VA_PAGE_BITS = PAGE_IDX_BITS * MAX_DEPTH;
    localparam int PA_PAGE_BITS = 40;

    // Physical page plus the line within that 4KB page
    localparam int LINE_ADDR_BITS = PA_PAGE_BITS + PAGE_IDX_BITS - WORD_SEL_BITS;

    // ============================================================
    // Entry format
    // ============================================================

    // Low status bits of an entry
    localparam int PTE_TERMINAL_BIT = 0;
    localparam int PTE_ERROR_BIT = 1;
    // Physical page field starts above the 4KB offset
    localparam int PTE_PAGE_LSB = 12;

    typedef logic [PAGE_IDX_BITS-1:0]  pt_idx_t;
    typedef logic [VA_PAGE_BITS-1:0]   va_page_t;
    typedef logic [PA_PAGE_BITS-1:0]   pa_page_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [DEPTH_BITS-1:0]     walk_depth_t;

    // Decoded status of one entry
    typedef struct packed
    {
        logic error;
        logic terminal;
    } pte_status_t;

    // ============================================================
    // Ports and state
    // ============================================================

    // Configuration, held steady by software
    typedef struct packed
    {
        pa_page_t root_page;
        logic     base_valid;
        logic     enable;
    } walk_csr_t;

    // Translation handed to the TLB
    typedef struct packed
    {
        va_page_t va_page;
        pa_page_t pa_page;
        // Set for a 2MB page
        logic     big_page;
    } tlb_fill_t;

    typedef enum logic [2:0]
    {
        IDLE,
        READ_REQ,
        WAIT_RSP,
        EVAL,
        DONE,
        ERROR
    } walk_state_t;

endpackage

// ==== src/pte_line_decoder.sv ====
// Page table line decoder
// Picks one entry from a response line and splits out its status and page

`timescale 1ns/1ps

module pte_line_decoder
    import pt_walk_pkg::*;
(
    // Full line from memory
    input  logic [LINE_BITS-1:0]     rsp_line,

    // Entry within the line
    input  logic [WORD_SEL_BITS-1:0] word_sel,

    output pte_status_t              pte_status,
    output pa_page_t                 next_page
);

    // Line viewed as entries, word 0 in the low bits
    logic [LINE_WORDS-1:0][PTE_BITS-1:0] line_words;

    // Selected entry
    logic [PTE_BITS-1:0] pte;

    // ============================================================
    // Entry select
    // ============================================================

    always_comb
    begin
        line_words = rsp_line;
        pte = line_words[word_sel];
    end

    // ============================================================
    // Field decode
    // ============================================================

    // Error bit marks a missing entry
    assign pte_status.error = pte[PTE_ERROR_BIT];

    // Terminal entry holds the translation itself
    assign pte_status.terminal = pte[PTE_TERMINAL_BIT];

    // Either the next table page or the translated page
    assign next_page = pte[PTE_PAGE_LSB +: PA_PAGE_BITS];

endmodule

// ==== src/va_index_tracker.sv ====
// Virtual page index tracker
// Shifts the virtual page so the current level's 9-bit index sits on top

`timescale 1ns/1ps

module va_index_tracker
    import pt_walk_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Start of a walk
    input  logic     load,
    input  va_page_t req_va,

    // Move down one level
    input  logic     level_step,

    output pt_idx_t  level_idx
);

    // Remaining index bits, current level first
    va_page_t va_shift;

    // Levels descended since the last load
    walk_depth_t steps_taken;

    // ============================================================
    // Index shift register
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            va_shift <= req_va;
        end
        else if (level_step)
        begin
            // Drop the used index, zero fill from below
            va_shift <= va_shift << PAGE_IDX_BITS;
        end
    end

    assign level_idx = va_shift[VA_PAGE_BITS-1 -: PAGE_IDX_BITS];

    // Step count
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            steps_taken <= '0;
        end
        else if (load)
        begin
            steps_taken <= '0;
        end
        else if (level_step)
        begin
            steps_taken <= steps_taken + walk_depth_t'(1);
        end
    end

    // A walk has four levels, so at most three steps
    step_limit_a: assert property (@(posedge clk) disable iff (reset)
        level_step && !load |-> steps_taken != walk_depth_t'(MAX_DEPTH - 1));

endmodule

// ==== src/walk_controller.sv ====
// Page walk FSM
// Tracks depth and current page, issues line reads and reports fills or errors

`timescale 1ns/1ps

module walk_controller
    import pt_walk_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        cfg_ready,
    input  pa_page_t    root_page,

    // Client request
    input  logic        req_valid,
    input  va_page_t    req_va,
    output logic        req_ready,

    // Index tracker control
    output logic        load,
    output logic        level_step,

    // Line read and response
    output logic        read_valid,
    input  logic        read_ready,
    output pa_page_t    cur_page,
    input  logic        rsp_valid,
    input  pte_status_t pte_status,
    input  pa_page_t    next_page,

    // TLB fill
    output logic        fill_valid,
    output tlb_fill_t   fill,
    input  logic        fill_ready,

    output logic        not_present,
    output logic        busy
);

    walk_state_t state;

    // Depth of the level being walked, 0 is the root
    walk_depth_t depth;

    // Virtual page reported with the fill
    va_page_t walk_va;

    // Entry sampled with the response
    pte_status_t status_q;
    pa_page_t    next_page_q;

    // EVAL outcome
    logic eval_error;
    logic eval_done;
    logic eval_next;

    // ============================================================
    // Entry rules
    // ============================================================

    always_comb
    begin
        eval_error = 1'b0;
        eval_done = 1'b0;
        eval_next = 1'b0;

        if (status_q.error)
        begin
            eval_error = 1'b1;
        end
        else if (status_q.terminal)
        begin
            // Only 4KB (depth 3) and 2MB (depth 2) leaves are legal
            if (depth >= walk_depth_t'(MAX_DEPTH - 2))
            begin
                eval_done = 1'b1;
            end
            else
            begin
                eval_error = 1'b1;
            end
        end
        else if (depth == walk_depth_t'(MAX_DEPTH - 1))
        begin
            // Pointer out of the last level
            eval_error = 1'b1;
        end
        else
        begin
            eval_next = 1'b1;
        end
    end

    // ============================================================
    // State and control registers
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            depth <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (load)
                    begin
                        state <= READ_REQ;
                        depth <= '0;
                    end
                end

                READ_REQ:
                begin
                    // Address holds until memory takes it
                    if (read_ready)
                    begin
                        state <= WAIT_RSP;
                    end
                end

                WAIT_RSP:
                begin
                    if (rsp_valid)
                    begin
                        state <= EVAL;
                    end
                end

                EVAL:
                begin
                    if (eval_error)
                    begin
                        state <= ERROR;
                    end
                    else if (eval_done)
                    begin
                        state <= DONE;
                    end
                    else
                    begin
                        state <= READ_REQ;
                        depth <= depth + walk_depth_t'(1);
                    end
                end

                DONE:
                begin
                    if (fill_ready)
                    begin
                        state <= IDLE;
                    end
                end

                // Sticky until reset
                ERROR:
                begin
                    state <= ERROR;
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Walk payload
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            walk_va <= req_va;
            cur_page <= root_page;
        end
        else if ((state == EVAL) && !eval_error)
        begin
            // Next table page, or the translated page at a leaf
            cur_page <= next_page_q;
        end

        if ((state == WAIT_RSP) && rsp_valid)
        begin
            status_q <= pte_status;
            next_page_q <= next_page;
        end
    end

    // ============================================================
    // Outputs
    // ============================================================

    assign req_ready = cfg_ready && (state == IDLE);
    assign load = req_valid && req_ready;
    assign level_step = (state == EVAL) && eval_next;

    assign read_valid = (state == READ_REQ);

    assign fill_valid = (state == DONE);
    assign fill.va_page = walk_va;
    assign fill.pa_page = cur_page;
    // A leaf at depth 2 maps 2MB
    assign fill.big_page = ~depth[0];

    assign not_present = (state == ERROR);
    assign busy = (state != IDLE) && (state != ERROR);

    // Read request and its address hold while memory stalls
    read_hold_a: assert property (@(posedge clk) disable iff (reset)
        read_valid && !read_ready |=> read_valid && $stable(cur_page));

    // Memory answers only an issued read
    rsp_in_wait_a: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> state == WAIT_RSP);

endmodule

// ==== src/pt_walker.sv ====
// Hierarchical page table walker top level
// Turns a virtual page into a TLB fill by reading table lines level by level

`timescale 1ns/1ps

module pt_walker
    import pt_walk_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,

    // Configuration
    input  walk_csr_t            csr,

    // Walk request from the client
    input  logic                 req_valid,
    input  va_page_t             req_va,
    output logic                 req_ready,

    // Page table line reads
    output logic                 read_valid,
    output line_addr_t           read_addr,
    input  logic                 read_ready,

    // Read response, one cycle pulse
    input  logic                 rsp_valid,
    input  logic [LINE_BITS-1:0] rsp_line,

    // TLB fill
    output logic                 fill_valid,
    output tlb_fill_t            fill,
    input  logic                 fill_ready,

    // Status
    output logic                 not_present,
    output logic                 busy
);

    // Walks start only once the root is valid and the walker enabled
    logic cfg_ready;

    // Controller to tracker
    logic load;
    logic level_step;

    // Index of the level being read
    pt_idx_t level_idx;

    // Current table page
    pa_page_t cur_page;

    // Decoded entry, combinational from the response line
    pte_status_t pte_status;
    pa_page_t    next_page;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg_ready <= 1'b0;
        end
        else
        begin
            cfg_ready <= csr.base_valid && csr.enable;
        end
    end

    // Upper index bits pick the line, the lower three pick the entry
    assign read_addr = {cur_page, level_idx[PAGE_IDX_BITS-1:WORD_SEL_BITS]};

    // ============================================================
    // Blocks
    // ============================================================

    walk_controller walk_controller_i
    (
        .clk         (clk),
        .reset       (reset),
        .cfg_ready   (cfg_ready),
        .root_page   (csr.root_page),
        .req_valid   (req_valid),
        .req_va      (req_va),
        .read_ready  (read_ready),
        .rsp_valid   (rsp_valid),
        .pte_status  (pte_status),
        .next_page   (next_page),
        .fill_ready  (fill_ready),
        .req_ready   (req_ready),
        .load        (load),
        .level_step  (level_step),
        .read_valid  (read_valid),
        .cur_page    (cur_page),
        .fill_valid  (fill_valid),
        .fill        (fill),
        .not_present (not_present),
        .busy        (busy)
    );

    va_index_tracker va_index_tracker_i
    (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .req_va     (req_va),
        .level_step (level_step),
        .level_idx  (level_idx)
    );

    pte_line_decoder pte_line_decoder_i
    (
        .rsp_line   (rsp_line),
        .word_sel   (level_idx[WORD_SEL_BITS-1:0]),
        .pte_status (pte_status),
        .next_page  (next_page)
    );

endmodule

// ==== test/pt_memory_model.sv ====
// Behavioral page table memory for the walker testbench
// Builds table lines from the test table and answers reads after random stalls

`timescale 1ns/1ps

module pt_memory_model
    import pt_walk_pkg::*;
#(
    parameter int NUM_TESTS = 1
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  pa_page_t             root_page,

    // Test table columns
    input  va_page_t             test_va [NUM_TESTS],
    input  pa_page_t             test_pa [NUM_TESTS],
    input  logic                 test_fill [NUM_TESTS],
    input  logic                 test_big [NUM_TESTS],

    // Expected address of the read that comes next
    input  int                   cur_test,
    input  int                   level_num,
    output line_addr_t           exp_addr,
    output logic                 exp_addr_valid,

    // Walker memory side
    input  logic                 read_valid,
    input  line_addr_t           read_addr,
    output logic                 read_ready,
    output logic                 rsp_valid,
    output logic [LINE_BITS-1:0] rsp_line,
    output logic                 fill_ready
);

    // Sparse table memory, one entry per line address
    logic [LINE_BITS-1:0] lines [line_addr_t];

    // Line address read at each level of each walk
    line_addr_t path_addr [NUM_TESTS][MAX_DEPTH];
    int         path_len [NUM_TESTS];

    // Next free table page
    pa_page_t next_free;
    integer   seed;

    // Bits 51:12 page, bit 1 error, bit 0 terminal
    function automatic logic [PTE_BITS-1:0] make_entry(pa_page_t page, logic err, logic term);
        return {12'h000, page, 10'h000, err, term};
    endfunction

    // ============================================================
    // Table construction
    // ============================================================

    task automatic build_tables();
        pa_page_t             page;
        pt_idx_t              idx;
        line_addr_t           addr;
        logic [LINE_BITS-1:0] line;
        logic [PTE_BITS-1:0]  entry;
        int                   leaf;
        int                   word;
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            page = root_page;
            // 2MB leaves sit one level higher
            leaf = test_big[t] ? 2 : 3;
            path_len[t] = leaf + 1;
            for (int d = 0; d <= leaf; d++)
            begin
                idx = pt_idx_t'(test_va[t] >> (9 * (3 - d)));
                addr = {page, idx[8:3]};
                word = int'(idx[2:0]);
                path_addr[t][d] = addr;
                line = lines.exists(addr) ? lines[addr] : '0;
                entry = line[word * 64 +: 64];
                if (d == leaf)
                begin
                    entry = test_fill[t] ? make_entry(test_pa[t], 1'b0, 1'b1)
                                         : make_entry('0, 1'b1, 1'b0);
                end
                else if (entry == '0)
                begin
                    // New table page, shared by later walks on the same path
                    entry = make_entry(next_free, 1'b0, 1'b0);
                    next_free = next_free + 40'h1;
                end
                page = entry[51:12];
                line[word * 64 +: 64] = entry;
                lines[addr] = line;
            end
        end
    endtask

    always_comb
    begin
        exp_addr = '0;
        exp_addr_valid = 1'b0;
        if ((cur_test >= 0) && (cur_test < NUM_TESTS))
        begin
            if ((level_num >= 0) && (level_num < path_len[cur_test]))
            begin
                exp_addr = path_addr[cur_test][level_num];
                exp_addr_valid = 1'b1;
            end
        end
    end

    // ============================================================
    // Read service
    // ============================================================

    // Ready lines stall about one cycle in four
    task automatic draw_stalls();
        read_ready = (($random(seed) & 3) != 0);
        fill_ready = (($random(seed) & 3) != 0);
    endtask

    initial
    begin
        int         delay;
        line_addr_t addr;
        seed = 32'h1a35;
        read_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp_line = '0;
        fill_ready = 1'b0;
        next_free = 40'h00_0010_0000;
        @(posedge clk);
        build_tables();
        forever
        begin
            @(posedge clk);
            if (!reset && read_valid && read_ready)
            begin
                addr = read_addr;
                delay = $random(seed) & 7;
                #1;
                draw_stalls();
                for (int i = 0; i < delay; i++)
                begin
                    @(posedge clk);
                    #1;
                    draw_stalls();
                end
                // One cycle response pulse
                rsp_valid = 1'b1;
                rsp_line = lines.exists(addr) ? lines[addr] : '0;
                @(posedge clk);
                #1;
                rsp_valid = 1'b0;
                draw_stalls();
            end
            else
            begin
                #1;
                draw_stalls();
            end
        end
    end

endmodule

// ==== test/pt_walk_tb.sv ====
// Page table walker testbench
// Runs a table of walks against a behavioral table memory and checks each outcome

`timescale 1ns/1ps

module pt_walk_tb
    import pt_walk_pkg::*;
;

    localparam int NUM_TESTS = 7;
    localparam int RESET_CYCLES = 5;
    // Worst case cycles for one level including stalls
    localparam int MAX_LEVEL_CYCLES = 40;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_DEPTH * MAX_LEVEL_CYCLES + 40;
    localparam pa_page_t ROOT_PAGE = 40'h00_0000_0100;

    logic                 clk;
    logic                 reset;
    walk_csr_t            csr;
    logic                 req_valid;
    va_page_t             req_va;
    logic                 req_ready;
    logic                 read_valid;
    line_addr_t           read_addr;
    logic                 read_ready;
    logic                 rsp_valid;
    logic [LINE_BITS-1:0] rsp_line;
    logic                 fill_valid;
    tlb_fill_t            fill;
    logic                 fill_ready;
    logic                 not_present;
    logic                 busy;

    // ============================================================
    // Test table
    // ============================================================

    string    test_name [NUM_TESTS];
    va_page_t test_va [NUM_TESTS];
    logic     test_fill [NUM_TESTS];
    pa_page_t test_pa [NUM_TESTS];
    logic     test_big [NUM_TESTS];

    // Walk in progress and reads seen so far
    int         cur_test;
    int         read_count;
    line_addr_t last_read_addr [NUM_TESTS];
    line_addr_t exp_addr;
    logic       exp_addr_valid;

    // Stall tracking
    logic       read_held;
    line_addr_t held_addr;
    logic       fill_held;
    tlb_fill_t  held_fill;

    pt_walker pt_walker_i
    (
        .clk         (clk),
        .reset       (reset),
        .csr         (csr),
        .req_valid   (req_valid),
        .req_va      (req_va),
        .req_ready   (req_ready),
        .read_valid  (read_valid),
        .read_addr   (read_addr),
        .read_ready  (read_ready),
        .rsp_valid   (rsp_valid),
        .rsp_line    (rsp_line),
        .fill_valid  (fill_valid),
        .fill        (fill),
        .fill_ready  (fill_ready),
        .not_present (not_present),
        .busy        (busy)
    );

    pt_memory_model #(.NUM_TESTS(NUM_TESTS)) pt_memory_model_i
    (
        .clk            (clk),
        .reset          (reset),
        .root_page      (ROOT_PAGE),
        .test_va        (test_va),
        .test_pa        (test_pa),
        .test_fill      (test_fill),
        .test_big       (test_big),
        .cur_test       (cur_test),
        .level_num      (read_count),
        .exp_addr       (exp_addr),
        .exp_addr_valid (exp_addr_valid),
        .read_valid     (read_valid),
        .read_addr      (read_addr),
        .read_ready     (read_ready),
        .rsp_valid      (rsp_valid),
        .rsp_line       (rsp_line),
        .fill_ready     (fill_ready)
    );

    task automatic stop_on_failure();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic compare_value(input string name, input string what,
                                 input logic [79:0] expected, input logic [79:0] actual);
        assert (expected === actual)
        else
        begin
            $display("CHECK FAILED %s %s expected %0h actual %0h", name, what, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic set_test(input int t, input string name, input va_page_t va,
                            input logic fill_exp, input pa_page_t pa, input logic big);
        test_name[t] = name;
        test_va[t] = va;
        test_fill[t] = fill_exp;
        test_pa[t] = pa;
        test_big[t] = big;
    endtask

    // Tests 0 and 1 differ only in the low word select bits of the last index
    task automatic load_table();
        set_test(0, "leaf4k_a",       36'h0_1234_5678, 1'b1, 40'h00_000a_bc01, 1'b0);
        set_test(1, "leaf4k_sibling", 36'h0_1234_5679, 1'b1, 40'h00_000a_bc77, 1'b0);
        set_test(2, "leaf4k_far",     36'h9_8765_4321, 1'b1, 40'h12_3456_789a, 1'b0);
        set_test(3, "leaf2m_a",       36'h3_0000_0000, 1'b1, 40'h00_0004_0200, 1'b1);
        set_test(4, "leaf2m_b",       36'h3_0004_0000, 1'b1, 40'h00_0004_0400, 1'b1);
        set_test(5, "leaf4k_shared",  36'h0_1234_0000, 1'b1, 40'h00_000f_edc0, 1'b0);
        // Error entry at depth 3
        set_test(6, "error_entry",    36'hf_ffff_f000, 1'b0, 40'h00_0000_0000, 1'b0);
    endtask

    // ============================================================
    // Clock, monitor and watchdog
    // ============================================================

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (!reset)
        begin
            // Stalled read and fill hold until taken
            if (read_held)
            begin
                compare_value(test_name[cur_test], "read_valid held", 80'd1, read_valid);
                compare_value(test_name[cur_test], "read_addr held", held_addr, read_addr);
            end
            if (fill_held)
            begin
                compare_value(test_name[cur_test], "fill_valid held", 80'd1, fill_valid);
                compare_value(test_name[cur_test], "fill held", held_fill, fill);
            end
            if (read_valid && read_ready)
            begin
                assert (exp_addr_valid)
                else
                begin
                    $display("Unexpected page table read in test %s", test_name[cur_test]);
                    stop_on_failure();
                end
                compare_value(test_name[cur_test], "read_addr", exp_addr, read_addr);
                last_read_addr[cur_test] <= read_addr;
                read_count <= read_count + 1;
            end
            if (req_valid && req_ready)
            begin
                read_count <= 0;
            end
        end
        read_held <= !reset && read_valid && !read_ready;
        held_addr <= read_addr;
        fill_held <= !reset && fill_valid && !fill_ready;
        held_fill <= fill;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * 10);
        $display("Timeout: the walks did not finish in the allowed time");
        stop_on_failure();
    end

    // ============================================================
    // Stimulus
    // ============================================================

    task automatic run_walk(input int t);
        logic done;
        logic got_fill;
        int   exp_reads;
        done = 1'b0;
        got_fill = 1'b0;
        exp_reads = test_big[t] ? 3 : 4;
        @(posedge clk);
        #1;
        cur_test = t;
        req_valid = 1'b1;
        req_va = test_va[t];
        @(posedge clk);
        while (!req_ready)
        begin
            @(posedge clk);
        end
        #1;
        req_valid = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            if (fill_valid && fill_ready)
            begin
                got_fill = 1'b1;
                done = 1'b1;
            end
            else if (not_present)
            begin
                done = 1'b1;
            end
            if (!not_present)
            begin
                compare_value(test_name[t], "busy during walk", 80'd1, busy);
            end
        end
        compare_value(test_name[t], "outcome is fill", test_fill[t], got_fill);
        compare_value(test_name[t], "read count", exp_reads, read_count);
        if (got_fill)
        begin
            compare_value(test_name[t], "fill va_page", test_va[t], fill.va_page);
            compare_value(test_name[t], "fill pa_page", test_pa[t], fill.pa_page);
            compare_value(test_name[t], "fill big_page", test_big[t], fill.big_page);
            // Back in IDLE one cycle after the fill
            @(posedge clk);
            compare_value(test_name[t], "busy after fill", 80'd0, busy);
            compare_value(test_name[t], "req_ready after fill", 80'd1, req_ready);
        end
        else
        begin
            // Error is sticky and blocks new requests
            repeat (10)
            begin
                @(posedge clk);
                compare_value(test_name[t], "req_ready after error", 80'd0, req_ready);
                compare_value(test_name[t], "not_present after error", 80'd1, not_present);
                compare_value(test_name[t], "busy after error", 80'd0, busy);
            end
        end
    endtask

    initial
    begin
        int wait_cycles;
        load_table();
        reset = 1'b1;
        req_valid = 1'b0;
        req_va = '0;
        csr.root_page = ROOT_PAGE;
        csr.base_valid = 1'b1;
        csr.enable = 1'b0;
        cur_test = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        // Pending request that must not start a walk
        req_valid = 1'b1;
        req_va = test_va[0];

        // Walker stays closed while disabled
        repeat (8)
        begin
            @(posedge clk);
            compare_value("csr_enable", "req_ready while disabled", 80'd0, req_ready);
            compare_value("csr_enable", "busy while disabled", 80'd0, busy);
            compare_value("csr_enable", "read_valid while disabled", 80'd0, read_valid);
            compare_value("csr_enable", "fill_valid while disabled", 80'd0, fill_valid);
            compare_value("csr_enable", "not_present while disabled", 80'd0, not_present);
        end
        #1;
        req_valid = 1'b0;
        csr.enable = 1'b1;
        wait_cycles = 0;
        @(posedge clk);
        while (!req_ready)
        begin
            assert (wait_cycles < 3)
            else
            begin
                $display("req_ready did not rise after the walker was enabled");
                stop_on_failure();
            end
            @(posedge clk);
            wait_cycles++;
        end

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            run_walk(t);
        end

        // Sibling pages come from one line
        compare_value("leaf4k_sibling", "shared last line", last_read_addr[0],
                      last_read_addr[1]);

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== tb.f ====
src/pt_walk_pkg.sv
src/pte_line_decoder.sv
src/va_index_tracker.sv
src/walk_controller.sv
src/pt_walker.sv
test/pt_memory_model.sv
test/pt_walk_tb.sv

// ==== Makefile ====
# Verilator build and run for the page table walker testbench

VERILATOR ?= verilator
TOP       ?= pt_walk_tb
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILE_LIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The log decides pass or fail
run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
